/* cache_pkg.sv */
package cache_pkg;

  // cache geometry
  localparam int ADDR_BITS  = 16;
  localparam int WORD_BITS  = 32;
  localparam int LINE_BYTES = 16;
  localparam int NUM_WAYS   = 4;  // tree plru wants a power of two
  localparam int NUM_SETS   = 8;

  localparam int OFFSET_BITS    = $clog2(LINE_BYTES);
  localparam int SET_BITS       = $clog2(NUM_SETS);
  localparam int TAG_BITS       = ADDR_BITS - SET_BITS - OFFSET_BITS;
  localparam int WORDS_PER_LINE = LINE_BYTES * 8 / WORD_BITS;
  localparam int WAY_BITS       = $clog2(NUM_WAYS);
  localparam int PLRU_BITS      = NUM_WAYS - 1;  // one bit per inner tree node

  typedef logic [ADDR_BITS-1:0]    addr_t;       // byte address
  typedef logic [TAG_BITS-1:0]     tag_t;
  typedef logic [SET_BITS-1:0]     set_idx_t;
  typedef logic [OFFSET_BITS-1:0]  offset_t;     // byte offset inside a line
  typedef logic [WORD_BITS-1:0]    word_t;
  typedef logic [LINE_BYTES*8-1:0] line_t;
  typedef logic [WAY_BITS-1:0]     way_idx_t;
  typedef logic [PLRU_BITS-1:0]    plru_bits_t;  // bit 0 is the root

  typedef struct packed {
    logic valid;
    logic dirty;  // line differs from the lower level
    tag_t tag;
  } tag_entry_t;

  // word request from the higher level
  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  we;
  } hc_req_t;

  // line returned by the lower level
  typedef struct packed {
    addr_t addr;
    line_t line;
  } lc_fill_t;

  // line read (we 0) or write-back (we 1) towards the lower level
  typedef struct packed {
    addr_t addr;
    line_t line;
    logic  we;
  } lc_req_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS_REQ,
    EVICT,
    EVICT_WAIT,
    WRITE,
    RESPOND,
    FLUSH
  } ctrl_state_e;

endpackage

/* req_capture.sv */
`timescale 1ns/1ps

module req_capture
  import cache_pkg::*;
(
  input  logic     clk_in,
  input  logic     rst_N_in,
  input  logic     capture_en,
  input  logic     hc_valid_in,
  input  hc_req_t  hc_req_in,
  input  logic     lc_valid_in,
  input  lc_fill_t lc_fill_in,
  input  logic     flush_in,
  output logic     hc_valid,
  output hc_req_t  hc_req,
  output logic     lc_valid,
  output lc_fill_t lc_fill,
  output logic     flush,
  output set_idx_t cur_set,
  output tag_t     cur_tag,
  output offset_t  cur_offset
);

  addr_t cur_addr;

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      hc_valid <= 1'b0;
      lc_valid <= 1'b0;
      flush    <= 1'b0;
    end else if (capture_en) begin
      hc_valid <= hc_valid_in;
      lc_valid <= lc_valid_in;
      flush    <= flush_in;
    end
  end

  // payload frozen while the controller is busy
  always_ff @(posedge clk_in) begin
    if (capture_en) begin
      hc_req  <= hc_req_in;
      lc_fill <= lc_fill_in;
    end
  end

  // fill address when a fill is held, else the request
  assign cur_addr = lc_valid ? lc_fill.addr : hc_req.addr;
  assign {cur_tag, cur_set, cur_offset} = cur_addr;

endmodule

/* tag_store.sv */
`timescale 1ns/1ps

module tag_store
  import cache_pkg::*;
(
  input  logic       clk_in,
  input  logic       rst_N_in,
  input  set_idx_t   cur_set,
  input  tag_t       cur_tag,
  input  way_idx_t   victim_way,
  input  logic       tag_we,
  input  way_idx_t   tag_way,
  input  tag_entry_t tag_entry,
  input  logic       flush_all,
  output logic       hit,
  output way_idx_t   hit_way,
  output tag_entry_t victim_entry
);

  tag_entry_t entries [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0] hit_vec;  // one bit per way

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = entries[w][cur_set].valid && (entries[w][cur_set].tag == cur_tag);
      if (hit_vec[w]) begin
        hit_way = way_idx_t'(w);
      end
    end
  end

  assign hit          = |hit_vec;
  assign victim_entry = entries[victim_way][cur_set];  // dirty check before a fill

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          entries[w][s] <= '0;
        end
      end
    end else if (flush_all) begin
      // tags kept, nothing is written back
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          entries[w][s].valid <= 1'b0;
          entries[w][s].dirty <= 1'b0;
        end
      end
    end else if (tag_we) begin
      entries[tag_way][cur_set] <= tag_entry;
    end
  end

  // fills only go to a way that does not already hold the line
  assert property (@(posedge clk_in) disable iff (!rst_N_in) $onehot0(hit_vec));

endmodule

/* data_store.sv */
`timescale 1ns/1ps

module data_store
  import cache_pkg::*;
(
  input  logic     clk_in,
  input  set_idx_t cur_set,
  input  offset_t  cur_offset,
  input  way_idx_t data_way,
  input  logic     line_we,
  input  logic     word_we,
  input  line_t    line_in,
  input  word_t    word_in,
  output word_t    rd_word,
  output line_t    rd_line
);

  line_t lines [NUM_WAYS][NUM_SETS];
  logic [$clog2(WORDS_PER_LINE)-1:0] word_sel;  // word within the line

  // low offset bits are ignored, accesses are word aligned
  assign word_sel = cur_offset[OFFSET_BITS-1 -: $clog2(WORDS_PER_LINE)];

  assign rd_line = lines[data_way][cur_set];  // whole line for eviction
  assign rd_word = rd_line[word_sel*WORD_BITS +: WORD_BITS];

  always_ff @(posedge clk_in) begin
    if (line_we) begin
      lines[data_way][cur_set] <= line_in;
    end else if (word_we) begin
      // merge one word, rest of the line untouched
      lines[data_way][cur_set][word_sel*WORD_BITS +: WORD_BITS] <= word_in;
    end
  end

endmodule

/* plru_policy.sv */
`timescale 1ns/1ps

module plru_policy
  import cache_pkg::*;
(
  input  logic     clk_in,
  input  logic     rst_N_in,
  input  set_idx_t cur_set,
  input  logic     touch_en,
  input  way_idx_t touch_way,
  output way_idx_t victim_way
);

  // bit 0 picks the half, bit 1 splits ways 0/1, bit 2 splits ways 2/3
  plru_bits_t tree [NUM_SETS];
  plru_bits_t cur_bits;

  assign cur_bits = tree[cur_set];

  // follow the pointers down to the victim
  assign victim_way = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        tree[s] <= '0;
      end
    end else if (touch_en) begin
      tree[cur_set][0] <= ~touch_way[1];  // root points at the other half
      if (touch_way[1]) begin
        tree[cur_set][2] <= ~touch_way[0];
      end else begin
        tree[cur_set][1] <= ~touch_way[0];
      end
    end
  end

  // one touch per lookup, never on consecutive cycles
  assert property (@(posedge clk_in) disable iff (!rst_N_in) touch_en |=> !touch_en);

endmodule

/* cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl
  import cache_pkg::*;
(
  input  logic       clk_in,
  input  logic       rst_N_in,
  input  logic       hc_valid,
  input  hc_req_t    hc_req,
  input  logic       lc_valid,
  input  lc_fill_t   lc_fill,
  input  logic       flush,
  input  logic       hit,
  input  way_idx_t   hit_way,
  input  way_idx_t   victim_way,
  input  tag_entry_t victim_entry,
  input  word_t      rd_word,
  input  line_t      rd_line,
  input  logic       hc_ready_in,
  input  logic       lc_ready_in,
  output logic       capture_en,
  output logic       tag_we,
  output way_idx_t   tag_way,
  output tag_entry_t tag_entry,
  output logic       flush_all,
  output logic       touch_en,
  output way_idx_t   touch_way,
  output logic       line_we,
  output logic       word_we,
  output way_idx_t   data_way,
  output logic       hc_ready_out,
  output logic       hc_valid_out,
  output addr_t      hc_addr_out,
  output word_t      hc_value_out,
  output logic       lc_valid_out,
  output lc_req_t    lc_req_out,
  output logic       lc_ready_out
);

  ctrl_state_e state, next_state;

  addr_t    cur_addr;      // fill address wins over the request
  tag_t     cur_tag;
  set_idx_t cur_set;
  way_idx_t use_way;       // way picked in LOOKUP
  way_idx_t way_r;         // ...and kept for the later states
  logic     evict_needed;
  logic     miss_pending;  // line asked for, fill not seen yet
  addr_t    line_addr;

  assign cur_addr  = lc_valid ? lc_fill.addr : hc_req.addr;
  assign cur_tag   = cur_addr[ADDR_BITS-1 -: TAG_BITS];
  assign cur_set   = cur_addr[OFFSET_BITS +: SET_BITS];
  assign line_addr = {hc_req.addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

  // a fill of a line that is already present lands on top of it
  assign use_way      = hit ? hit_way : victim_way;
  assign evict_needed = !hit && victim_entry.valid && victim_entry.dirty;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (flush) begin
          next_state = FLUSH;
        end else if (lc_valid) begin  // fills go first
          next_state = LOOKUP;
        end else if (hc_valid && !miss_pending) begin
          next_state = LOOKUP;
        end
      end
      LOOKUP: begin
        if (lc_valid) begin
          next_state = evict_needed ? EVICT : WRITE;
        end else if (!hit) begin
          next_state = MISS_REQ;
        end else begin
          next_state = hc_req.we ? WRITE : RESPOND;
        end
      end
      MISS_REQ:   next_state = lc_ready_in ? IDLE : MISS_REQ;
      EVICT:      next_state = EVICT_WAIT;
      EVICT_WAIT: next_state = lc_ready_in ? WRITE : EVICT_WAIT;
      WRITE:      next_state = IDLE;
      RESPOND:    next_state = hc_ready_in ? IDLE : RESPOND;
      FLUSH:      next_state = IDLE;
      default:    next_state = IDLE;
    endcase
  end

  // inputs are resampled on every cycle that ends in IDLE
  assign capture_en = (next_state == IDLE);

  // datapath strobes, straight from the state
  assign touch_en  = (state == LOOKUP) && (lc_valid || hit);
  assign touch_way = use_way;
  assign data_way  = (state == LOOKUP) ? hit_way : way_r;  // hit word read in LOOKUP
  assign tag_we    = (state == WRITE);
  assign tag_way   = way_r;
  assign tag_entry = '{valid: 1'b1, dirty: !lc_valid, tag: cur_tag};  // fills stay clean
  assign line_we   = (state == WRITE) && lc_valid;
  assign word_we   = (state == WRITE) && !lc_valid;
  assign flush_all = (state == FLUSH);

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state         <= IDLE;
      miss_pending  <= 1'b0;
      way_r         <= '0;
      hc_ready_out  <= 1'b0;
      hc_valid_out  <= 1'b0;
      lc_valid_out  <= 1'b0;
      lc_ready_out  <= 1'b0;
      lc_req_out.we <= 1'b0;
    end else begin
      state        <= next_state;
      hc_ready_out <= 1'b0;  // both readies are single-cycle pulses
      lc_ready_out <= 1'b0;
      case (state)
        IDLE: begin
          if (flush) begin
            hc_ready_out <= 1'b1;  // flush taken
          end else if (lc_valid) begin
            lc_ready_out <= 1'b1;
            miss_pending <= 1'b0;
          end
        end
        LOOKUP: begin
          way_r <= use_way;
          if (lc_valid) begin
            if (evict_needed) begin
              // victim tag is caught now, the plru moves on at this edge
              lc_req_out.addr <= {victim_entry.tag, cur_set, {OFFSET_BITS{1'b0}}};
              lc_req_out.we   <= 1'b1;
            end
          end else if (!hit) begin
            // request left unanswered, requester keeps it up until the fill
            miss_pending    <= 1'b1;
            lc_valid_out    <= 1'b1;
            lc_req_out.addr <= line_addr;
            lc_req_out.we   <= 1'b0;
          end else begin
            hc_ready_out <= 1'b1;  // hits are accepted here
            if (!hc_req.we) begin
              hc_valid_out <= 1'b1;
              hc_addr_out  <= hc_req.addr;
              hc_value_out <= rd_word;
            end
          end
        end
        MISS_REQ: begin
          if (lc_ready_in) begin
            lc_valid_out <= 1'b0;
          end
        end
        EVICT: begin
          lc_valid_out    <= 1'b1;
          lc_req_out.line <= rd_line;  // victim line
        end
        EVICT_WAIT: begin
          if (lc_ready_in) begin
            lc_valid_out  <= 1'b0;
            lc_req_out.we <= 1'b0;
          end
        end
        RESPOND: begin
          if (hc_ready_in) begin
            hc_valid_out <= 1'b0;  // value stays put until taken
          end
        end
        default: begin
        end
      endcase
    end
  end

  // one outward transfer at a time
  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    !(hc_valid_out && lc_valid_out));

  // plru only moves in a LOOKUP entered from IDLE with the inputs frozen
  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    touch_en |-> $past(!capture_en) && $past(state == IDLE));

endmodule

/* cache_top.sv */
`timescale 1ns/1ps

module cache_top
  import cache_pkg::*;
(
  input  logic     clk_in,
  input  logic     rst_N_in,
  // higher level
  input  logic     hc_valid_in,
  input  hc_req_t  hc_req_in,
  input  logic     flush_in,
  input  logic     hc_ready_in,
  output logic     hc_ready_out,
  output logic     hc_valid_out,
  output addr_t    hc_addr_out,
  output word_t    hc_value_out,
  // lower level
  output logic     lc_valid_out,
  output lc_req_t  lc_req_out,
  output logic     lc_ready_out,
  input  logic     lc_valid_in,
  input  lc_fill_t lc_fill_in,
  input  logic     lc_ready_in
);

  // captured inputs
  logic       hc_valid;
  hc_req_t    hc_req;
  logic       lc_valid;
  lc_fill_t   lc_fill;
  logic       flush;
  set_idx_t   cur_set;
  tag_t       cur_tag;
  offset_t    cur_offset;
  logic       capture_en;

  // tag and replacement side
  logic       hit;
  way_idx_t   hit_way;
  way_idx_t   victim_way;
  tag_entry_t victim_entry;
  logic       tag_we;
  way_idx_t   tag_way;
  tag_entry_t tag_entry;
  logic       flush_all;
  logic       touch_en;
  way_idx_t   touch_way;

  // data side
  word_t      rd_word;
  line_t      rd_line;
  logic       line_we;
  logic       word_we;
  way_idx_t   data_way;

  cache_ctrl cache_ctrl_inst (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .hc_valid     (hc_valid),
    .hc_req       (hc_req),
    .lc_valid     (lc_valid),
    .lc_fill      (lc_fill),
    .flush        (flush),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_entry (victim_entry),
    .rd_word      (rd_word),
    .rd_line      (rd_line),
    .hc_ready_in  (hc_ready_in),
    .lc_ready_in  (lc_ready_in),
    .capture_en   (capture_en),
    .tag_we       (tag_we),
    .tag_way      (tag_way),
    .tag_entry    (tag_entry),
    .flush_all    (flush_all),
    .touch_en     (touch_en),
    .touch_way    (touch_way),
    .line_we      (line_we),
    .word_we      (word_we),
    .data_way     (data_way),
    .hc_ready_out (hc_ready_out),
    .hc_valid_out (hc_valid_out),
    .hc_addr_out  (hc_addr_out),
    .hc_value_out (hc_value_out),
    .lc_valid_out (lc_valid_out),
    .lc_req_out   (lc_req_out),
    .lc_ready_out (lc_ready_out)
  );

  req_capture req_capture_inst (
    .clk_in      (clk_in),
    .rst_N_in    (rst_N_in),
    .capture_en  (capture_en),
    .hc_valid_in (hc_valid_in),
    .hc_req_in   (hc_req_in),
    .lc_valid_in (lc_valid_in),
    .lc_fill_in  (lc_fill_in),
    .flush_in    (flush_in),
    .hc_valid    (hc_valid),
    .hc_req      (hc_req),
    .lc_valid    (lc_valid),
    .lc_fill     (lc_fill),
    .flush       (flush),
    .cur_set     (cur_set),
    .cur_tag     (cur_tag),
    .cur_offset  (cur_offset)
  );

  tag_store tag_store_inst (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .cur_set      (cur_set),
    .cur_tag      (cur_tag),
    .victim_way   (victim_way),
    .tag_we       (tag_we),
    .tag_way      (tag_way),
    .tag_entry    (tag_entry),
    .flush_all    (flush_all),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_entry (victim_entry)
  );

  data_store data_store_inst (
    .clk_in     (clk_in),
    .cur_set    (cur_set),
    .cur_offset (cur_offset),
    .data_way   (data_way),
    .line_we    (line_we),
    .word_we    (word_we),
    .line_in    (lc_fill.line),  // fills always write the whole line
    .word_in    (hc_req.wdata),
    .rd_word    (rd_word),
    .rd_line    (rd_line)
  );

  plru_policy plru_policy_inst (
    .clk_in     (clk_in),
    .rst_N_in   (rst_N_in),
    .cur_set    (cur_set),
    .touch_en   (touch_en),
    .touch_way  (touch_way),
    .victim_way (victim_way)
  );

endmodule

/* cache_checker.sv */
`timescale 1ns/1ps

module cache_checker
  import cache_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_N_in,
  input  logic        hc_valid_out,
  input  logic        hc_ready_in,
  input  addr_t       hc_addr_out,
  input  word_t       hc_value_out,
  input  logic        lc_valid_out,
  input  lc_req_t     lc_req_out,
  input  logic        test_end,     // one cycle after each op is done
  input  logic        run_done,
  input  logic [15:0] test_num,
  input  logic [7:0]  test_op,
  input  addr_t       test_addr,
  input  word_t       test_expect,
  input  logic [3:0]  test_misses,
  output int          err_count
);

  int    pass_count;
  int    fail_count;
  logic  test_bad;        // stability or line address error in this test
  int    rd_reqs;         // line reads seen in this test
  logic  resp_open;       // result shown but not yet taken
  word_t held_value;
  addr_t held_addr;
  logic  got_result;
  word_t got_value;
  addr_t got_addr;
  logic  prev_lc_valid;
  logic  summary_done;

  assign err_count = fail_count;

  function automatic string test_name();
    return $sformatf("t%0d_%c_%h", test_num, test_op, test_addr);
  endfunction

  // first byte of the line that holds the address
  function automatic addr_t line_base(input addr_t a);
    return a & ~addr_t'(LINE_BYTES - 1);
  endfunction

  task check_test();
    logic bad;
    bad = test_bad;
    if (rd_reqs != int'(test_misses)) begin
      $display("CHECK FAILED %s line requests expected %0d actual %0d",
               test_name(), test_misses, rd_reqs);
      bad = 1'b1;
    end
    if (test_op == "R") begin
      if (!got_result) begin
        $display("%s read finished without a result being taken", test_name());
        bad = 1'b1;
      end else begin
        if (got_value !== test_expect) begin
          $display("CHECK FAILED %s value expected %h actual %h",
                   test_name(), test_expect, got_value);
          bad = 1'b1;
        end
        if (got_addr !== test_addr) begin
          $display("CHECK FAILED %s addr expected %h actual %h",
                   test_name(), test_addr, got_addr);
          bad = 1'b1;
        end
      end
    end
    if (bad) begin
      fail_count++;
    end else begin
      pass_count++;
      $display("%s ok", test_name());
    end
    got_result = 1'b0;
    rd_reqs    = 0;
    test_bad   = 1'b0;
  endtask

  always @(posedge clk_in) begin
    if (!rst_N_in) begin
      pass_count    = 0;
      fail_count    = 0;
      test_bad      = 1'b0;
      rd_reqs       = 0;
      resp_open     = 1'b0;
      got_result    = 1'b0;
      prev_lc_valid = 1'b0;
      summary_done  = 1'b0;
    end else begin
      // result must not move while the requester stalls
      if (hc_valid_out) begin
        if (resp_open && hc_value_out !== held_value) begin
          $display("CHECK FAILED %s held value expected %h actual %h",
                   test_name(), held_value, hc_value_out);
          test_bad = 1'b1;
        end
        if (resp_open && hc_addr_out !== held_addr) begin
          $display("CHECK FAILED %s held addr expected %h actual %h",
                   test_name(), held_addr, hc_addr_out);
          test_bad = 1'b1;
        end
        held_value = hc_value_out;
        held_addr  = hc_addr_out;
        resp_open  = !hc_ready_in;
        if (hc_ready_in) begin  // taken here
          got_result = 1'b1;
          got_value  = hc_value_out;
          got_addr   = hc_addr_out;
        end
      end else begin
        resp_open = 1'b0;
      end
      // count new line reads but not write-backs
      if (lc_valid_out && !prev_lc_valid && !lc_req_out.we) begin
        rd_reqs++;
        if (lc_req_out.addr !== line_base(test_addr)) begin
          $display("CHECK FAILED %s line address expected %h actual %h",
                   test_name(), line_base(test_addr), lc_req_out.addr);
          test_bad = 1'b1;
        end
      end
      prev_lc_valid = lc_valid_out;
      if (test_end) begin
        check_test();
      end
      if (run_done && !summary_done) begin
        $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
        summary_done = 1'b1;
      end
    end
  end

endmodule

/* tb_cache.sv */
`timescale 1ns/1ps

module tb_cache
  import cache_pkg::*;
();

  logic     clk_in;
  logic     rst_N_in;
  logic     hc_valid_in;
  hc_req_t  hc_req_in;
  logic     flush_in;
  logic     hc_ready_in;
  logic     hc_ready_out;
  logic     hc_valid_out;
  addr_t    hc_addr_out;
  word_t    hc_value_out;
  logic     lc_valid_out;
  lc_req_t  lc_req_out;
  logic     lc_ready_out;
  logic     lc_valid_in;
  lc_fill_t lc_fill_in;
  logic     lc_ready_in;

  // current test as seen by the checker
  logic        test_end;
  logic        run_done;
  logic [15:0] test_num;
  logic [7:0]  test_op;
  addr_t       test_addr;
  word_t       test_expect;
  logic [3:0]  test_misses;
  int          err_count;

  byte        ops [$];
  addr_t      addrs [$];
  word_t      wdatas [$];
  word_t      expects [$];
  logic [3:0] misses [$];
  logic       loaded;

  word_t mem [0:(1<<(ADDR_BITS-2))-1];  // word-indexed lower level

  cache_top cache_top_inst (.*);

  cache_checker cache_checker_inst (.*);

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  // lower level model answers write-backs and line reads
  initial begin
    lc_req_t req;
    line_t   fill;
    for (int i = 0; i < (1 << (ADDR_BITS - 2)); i++) begin
      mem[i] = 32'hc0de0000 + (i << 2);  // value follows the byte address
    end
    forever begin
      @(negedge clk_in);
      if (rst_N_in && lc_valid_out && !lc_ready_in) begin
        req         = lc_req_out;
        lc_ready_in = 1'b1;
        @(negedge clk_in);
        lc_ready_in = 1'b0;
        if (req.we) begin
          for (int w = 0; w < WORDS_PER_LINE; w++) begin
            mem[req.addr[ADDR_BITS-1:2] + w] = req.line[w*WORD_BITS +: WORD_BITS];
          end
        end else begin
          repeat (2) @(negedge clk_in);
          for (int w = 0; w < WORDS_PER_LINE; w++) begin
            fill[w*WORD_BITS +: WORD_BITS] = mem[req.addr[ADDR_BITS-1:2] + w];
          end
          lc_fill_in  = '{addr: req.addr, line: fill};
          lc_valid_in = 1'b1;
          do @(negedge clk_in); while (!lc_ready_out);
          lc_valid_in = 1'b0;
        end
      end
    end
  end

  task automatic run_op(input byte op, input addr_t a, input word_t wd);
    if (op == "F") begin
      flush_in = 1'b1;
      do @(negedge clk_in); while (!hc_ready_out);
      flush_in = 1'b0;
    end else begin
      hc_req_in   = '{addr: a, wdata: wd, we: (op == "W")};
      hc_valid_in = 1'b1;  // held through any miss and refill
      do @(negedge clk_in); while (!hc_ready_out);
      hc_valid_in = 1'b0;
      if (op == "R") begin
        while (!hc_valid_out) @(negedge clk_in);
        repeat (3) @(negedge clk_in);  // stall the result
        hc_ready_in = 1'b1;
        @(negedge clk_in);
        hc_ready_in = 1'b0;
      end
    end
    @(negedge clk_in);
    test_end = 1'b1;
    @(negedge clk_in);
    test_end = 1'b0;
  endtask

  // comment lines in the golden file start with #
  task automatic load_golden();
    int    fd;
    int    code;
    string tok;
    string rest;
    addr_t a;
    word_t wd;
    word_t ex;
    int    ms;
    fd = $fopen("cache_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open cache_golden.txt so no tests can run");
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) break;
        if (tok.getc(0) == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%h %h %h %d", a, wd, ex, ms);
          ops.push_back(tok.getc(0));
          addrs.push_back(a);
          wdatas.push_back(wd);
          expects.push_back(ex);
          misses.push_back(ms[3:0]);
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    loaded      = 1'b0;
    rst_N_in    = 1'b0;
    hc_valid_in = 1'b0;
    hc_req_in   = '0;
    flush_in    = 1'b0;
    hc_ready_in = 1'b0;
    lc_valid_in = 1'b0;
    lc_fill_in  = '0;
    lc_ready_in = 1'b0;
    test_end    = 1'b0;
    run_done    = 1'b0;
    test_num    = '0;
    test_op     = "R";
    test_addr   = '0;
    test_expect = '0;
    test_misses = '0;
    load_golden();
    loaded = 1'b1;
    repeat (2) @(posedge clk_in);
    @(negedge clk_in);
    rst_N_in = 1'b1;
    for (int t = 0; t < ops.size(); t++) begin
      test_num    = t[15:0];
      test_op     = ops[t];
      test_addr   = addrs[t];
      test_expect = expects[t];
      test_misses = misses[t];
      run_op(ops[t], addrs[t], wdatas[t]);
    end
    run_done = 1'b1;
    repeat (2) @(negedge clk_in);
    if (err_count == 0 && ops.size() > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog allows 60 cycles per golden line
  initial begin
    wait (loaded);
    repeat (ops.size() * 60 + 10) @(posedge clk_in);
    $display("timeout, the cache stopped answering before all tests finished");
    $display("Test failed");
    $finish;
  end

endmodule

/* cache_golden.txt */
# op addr wdata expect misses : op R read, W write, F flush
# expect is the read value, misses the line read requests the op causes
R 0000 00000000 c0de0000 1
R 0080 00000000 c0de0080 1
R 0100 00000000 c0de0100 1
R 0180 00000000 c0de0180 1
R 0004 00000000 c0de0004 0
R 0200 00000000 c0de0200 1
R 0000 00000000 c0de0000 0
R 0100 00000000 c0de0100 0
R 0188 00000000 c0de0188 0
R 0200 00000000 c0de0200 0
R 0080 00000000 c0de0080 1
W 0014 deadbeef 00000000 1
R 0014 00000000 deadbeef 0
R 0018 00000000 c0de0018 0
R 0010 00000000 c0de0010 0
R 0090 00000000 c0de0090 1
R 0110 00000000 c0de0110 1
R 0190 00000000 c0de0190 1
R 0210 00000000 c0de0210 1
R 0014 00000000 deadbeef 1
W 0024 12345678 00000000 1
R 0024 00000000 12345678 0
F 0000 00000000 00000000 0
R 0024 00000000 c0de0024 1

/* vlog.f */
cache_pkg.sv
req_capture.sv
tag_store.sv
data_store.sv
plru_policy.sv
cache_ctrl.sv
cache_top.sv
cache_checker.sv
tb_cache.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_cache
FILELIST  ?= vlog.f
LOG       ?= sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	elif ! grep -q "Test completed successfully" $(LOG); then \
	  echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
